//--- smc_testdata.hex
// one word per record: op, arg, expected value, two hex digits each
// op 01 send code, 02 read buffer, 03 cmd acked, 04 cmd nacked, 05 read status, 06 bad address
// status idle after reset
050000
// two codes back in order
011C00 013200 02001C 020032
// empty read gives 00, later code unharmed
020000 012100 020021
// nine codes into an 8 deep buffer
011500 011D00 012400 012D00 012C00 013500 013C00 014300
014400
// first eight come back, the ninth is gone
020015 02001D 020024 02002D 02002C 020035 02003C 020043
020000
// command acked by keyboard
03EDED 0500FA
// command nacked by keyboard
04F4F4 0500FE
// write to 0x33 gets no ack, status unchanged
063301 0500FE

//--- project.f
+incdir+.
smc_pkg.sv
smc_if.sv
i2c_target.sv
ps2_port.sv
scan_fifo.sv
smc_regs.sv
smc_top.sv
tb_smc.sv

//--- Makefile
# Verilator build for the system management controller
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing
TOP       := tb_smc
RTL_TOP   := smc_top
FILELIST  := project.f
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

sim: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tb_smc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the system management controller
// i2c host and ps2 keyboard models on open-drain lines,
// test records from a data file, watchdog and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "smc_macros.svh"

module tb_smc;

    localparam longint US_T      = 4 * `SMC_CLKS_PER_US;    // time units per us
    localparam longint PS2_REC_T = (100 + 13 * 40) * US_T;  // inhibit plus one frame
    localparam longint I2C_REC_T = 40 * 40 * 4;             // ~40 scl periods
    localparam longint MARGIN_T  = 1000 * US_T;
    localparam int     MAX_REC   = 64;

    logic clk6x = 1'b0;
    logic resetn;
    logic sda_h;                // host side of sda, 1 = released
    logic scl_h;
    logic kbd_clk;              // keyboard side, 1 = released
    logic kbd_data;
    wire  sda_drv;
    wire  kclk_drv;
    wire  kdata_drv;

    // wired-and open-drain lines
    wire sda_line   = sda_h & ~sda_drv;
    wire kclk_line  = kbd_clk & ~kclk_drv;
    wire kdata_line = kbd_data & ~kdata_drv;

    logic [23:0] recs [MAX_REC];    // op, arg, expected
    int   n_rec;
    int   rec_idx;
    int   errors;
    int   checks;
    int   inhibits;                 // host clock inhibits seen
    logic kclk_drv_q = 1'b0;
    logic loaded = 1'b0;

    smc_top dut_i (
        .clk6x                 (clk6x),
        .resetn                (resetn),
        .i2c_sda_i             (sda_line),
        .i2c_scl_i             (scl_h),       // no stretching, host owns scl
        .i2c_sda_drive_low_o   (sda_drv),
        .ps2k_clk_i            (kclk_line),
        .ps2k_data_i           (kdata_line),
        .ps2k_clk_drive_low_o  (kclk_drv),
        .ps2k_data_drive_low_o (kdata_drv)
    );

    always #2 clk6x = ~clk6x;

    always @(posedge clk6x)
    begin
        kclk_drv_q <= kclk_drv;
        if (kclk_drv && !kclk_drv_q)
            inhibits <= inhibits + 1;   // start of a command transmit
    end

    task wait_cycles(input int n);
        repeat (n) @(posedge clk6x);
    endtask

    task wait_us(input int n);
        wait_cycles(n * `SMC_CLKS_PER_US);
    endtask

    task check_value(input string what, input logic [7:0] got, input logic [7:0] expv);
        checks++;
        assert (got === expv)
        else
        begin
            errors++;
            $display("CHECK FAILED record %0d: %s got %h exp %h", rec_idx, what, got, expv);
        end
    endtask

    // start or repeated start, scl ends low
    task i2c_start;
        sda_h <= 1'b1;
        wait_cycles(10);
        scl_h <= 1'b1;
        wait_cycles(20);
        sda_h <= 1'b0;          // sda falls while scl high
        wait_cycles(20);
        scl_h <= 1'b0;
        wait_cycles(10);
    endtask

    task i2c_stop;
        sda_h <= 1'b0;
        wait_cycles(10);
        scl_h <= 1'b1;
        wait_cycles(20);
        sda_h <= 1'b1;          // sda rises while scl high
        wait_cycles(20);
    endtask

    // one 40 cycle scl period, data set mid low phase
    task i2c_bit_out(input logic b);
        sda_h <= b;
        wait_cycles(10);
        scl_h <= 1'b1;
        wait_cycles(20);
        scl_h <= 1'b0;
        wait_cycles(10);
    endtask

    task i2c_bit_in(output logic b);
        sda_h <= 1'b1;
        wait_cycles(10);
        scl_h <= 1'b1;
        wait_cycles(10);
        b = sda_line;           // mid high phase
        wait_cycles(10);
        scl_h <= 1'b0;
        wait_cycles(10);
    endtask

    task i2c_write_byte(input logic [7:0] d, output logic ack_n);
        int i;
        for (i = 7; i >= 0; i--)
            i2c_bit_out(d[i]);  // msb first
        i2c_bit_in(ack_n);
    endtask

    task i2c_read_byte(input logic nack, output logic [7:0] d);
        logic b;
        int   i;
        for (i = 7; i >= 0; i--)
        begin
            i2c_bit_in(b);
            d[i] = b;
        end
        i2c_bit_out(nack);
    endtask

    task reg_write(input logic [7:0] regnum, input logic [7:0] data);
        logic ack_n;
        i2c_start;
        i2c_write_byte({`SMC_I2C_ADDR, 1'b0}, ack_n);
        check_value("i2c_sda addr ack", {7'b0, ack_n}, 8'h00);
        i2c_write_byte(regnum, ack_n);
        check_value("i2c_sda reg ack", {7'b0, ack_n}, 8'h00);
        i2c_write_byte(data, ack_n);
        check_value("i2c_sda data ack", {7'b0, ack_n}, 8'h00);
        i2c_stop;
    endtask

    // register number write, repeated start, one byte read with nack
    task reg_read(input logic [7:0] regnum, output logic [7:0] data);
        logic ack_n;
        i2c_start;
        i2c_write_byte({`SMC_I2C_ADDR, 1'b0}, ack_n);
        check_value("i2c_sda addr ack", {7'b0, ack_n}, 8'h00);
        i2c_write_byte(regnum, ack_n);
        check_value("i2c_sda reg ack", {7'b0, ack_n}, 8'h00);
        i2c_start;
        i2c_write_byte({`SMC_I2C_ADDR, 1'b1}, ack_n);
        check_value("i2c_sda addr ack", {7'b0, ack_n}, 8'h00);
        i2c_read_byte(1'b1, data);
        i2c_stop;
    endtask

    // full command write to some other address
    task bad_addr_write(input logic [6:0] addr, output logic ack_n);
        logic dummy;
        i2c_start;
        i2c_write_byte({addr, 1'b0}, ack_n);
        i2c_write_byte(`SMCREG_KBD_CMD, dummy);
        i2c_write_byte(8'hF4, dummy);
        i2c_stop;
    endtask

    // device to host frame, 40 us clock, data set while clock high
    task kbd_send(input logic [7:0] code);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, ~^code, code, 1'b0};    // stop, odd parity, data, start
        for (i = 0; i < 11; i++)
        begin
            kbd_data <= frame[i];
            wait_us(20);
            kbd_clk <= 1'b0;                    // port samples on this fall
            wait_us(20);
            kbd_clk <= 1'b1;
        end
        wait_us(20);
    endtask

    // host to device frame, then ack or nack bit
    task kbd_receive(input logic give_ack, output logic [7:0] data, output logic frame_ok);
        logic [9:0] bits;       // d0..d7, parity, stop
        logic       start_ok;
        int         i;
        while (!kclk_drv)       // inhibit may already be on
            @(negedge clk6x);
        while (kclk_drv)
            @(negedge clk6x);
        wait_us(10);
        start_ok = !kdata_line;
        for (i = 0; i < 10; i++)
        begin
            kbd_clk <= 1'b0;
            wait_us(20);
            kbd_clk <= 1'b1;
            wait_us(10);
            bits[i] = kdata_line;   // host moves data on falls only
            wait_us(10);
        end
        kbd_data <= !give_ack;      // low = ack
        wait_us(10);
        kbd_clk <= 1'b0;
        wait_us(20);
        kbd_clk <= 1'b1;
        wait_us(20);
        kbd_data <= 1'b1;
        data = bits[7:0];
        frame_ok = start_ok & (^bits[8:0]) & bits[9];
    endtask

    initial
    begin
        logic [7:0] op;
        logic [7:0] arg;
        logic [7:0] expv;
        logic [7:0] got;
        logic       ok;
        int         inh_before;
        int         i;

        resetn = 1'b0;
        sda_h = 1'b1;
        scl_h = 1'b1;
        kbd_clk = 1'b1;
        kbd_data = 1'b1;
        for (i = 0; i < MAX_REC; i++)
            recs[i] = '0;           // op 00 ends the list
        $readmemh("smc_testdata.hex", recs);
        n_rec = 0;
        while (n_rec < MAX_REC && recs[n_rec][23:16] != 8'h00)
            n_rec++;
        loaded = 1'b1;

        repeat (5) @(posedge clk6x);
        resetn <= 1'b1;
        wait_cycles(20);

        for (rec_idx = 0; rec_idx < n_rec; rec_idx++)
        begin
            op = recs[rec_idx][23:16];
            arg = recs[rec_idx][15:8];
            expv = recs[rec_idx][7:0];
            case (op)
                8'h01: kbd_send(arg);
                8'h02:
                begin
                    reg_read(`SMCREG_KBD_BUF, got);
                    check_value("kbd_buf", got, expv);
                end
                8'h03, 8'h04:
                begin
                    reg_write(`SMCREG_KBD_CMD, arg);
                    kbd_receive(op == 8'h03, got, ok);
                    check_value("ps2k_cmd", got, expv);
                    assert (ok)
                    else
                    begin
                        errors++;
                        $display("record %0d: command frame has a bad start, parity or stop bit",
                            rec_idx);
                    end
                end
                8'h05:
                begin
                    reg_read(`SMCREG_KBD_STAT, got);
                    check_value("kbd_stat", got, expv);
                end
                8'h06:
                begin
                    inh_before = inhibits;
                    bad_addr_write(arg[6:0], ok);
                    check_value("i2c_sda ack slot", {7'b0, ok}, expv);
                    wait_us(4);
                    assert (inhibits == inh_before)
                    else
                    begin
                        errors++;
                        $display("record %0d: keyboard got a command after a wrong-address write",
                            rec_idx);
                    end
                end
                default:
                begin
                    errors++;
                    $display("record %0d: unknown operation in the data file", rec_idx);
                end
            endcase
        end

        $display("summary: %0d records, %0d checks, %0d errors", n_rec, checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // longest record is a command transmit plus its i2c write
    initial
    begin
        wait (loaded);
        #(n_rec * (PS2_REC_T + I2C_REC_T) + MARGIN_T);
        $display("watchdog: run did not finish in time, stuck at record %0d", rec_idx);
        $display("summary: %0d records, %0d checks, %0d errors", n_rec, checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- smc_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system management controller top
// i2c target at 0x42 giving access to one ps2 keyboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "smc_macros.svh"

module smc_top (
    input  logic clk6x,                 // 48 MHz
    input  logic resetn,                // sync, active low
    input  logic i2c_sda_i,
    input  logic i2c_scl_i,
    output logic i2c_sda_drive_low_o,
    input  logic ps2k_clk_i,
    input  logic ps2k_data_i,
    output logic ps2k_clk_drive_low_o,
    output logic ps2k_data_drive_low_o
);
    import smc_pkg::*;

    i2c_dev_if dev_if ();
    ps2_cmd_if cmd_if ();

    smc_byte_t ps2k_code;
    logic      ps2k_code_v;
    smc_byte_t fifo_rdata;
    logic      fifo_empty;
    logic      fifo_full;
    logic      fifo_enq;
    logic      fifo_deq;

    i2c_target i2c_i (
        .clk6x           (clk6x),
        .resetn          (resetn),
        .sda_i           (i2c_sda_i),
        .scl_i           (i2c_scl_i),
        .sda_drive_low_o (i2c_sda_drive_low_o),
        .dev             (dev_if)
    );

    ps2_port ps2k_i (
        .clk6x                (clk6x),
        .resetn               (resetn),
        .ps2_clk_i            (ps2k_clk_i),
        .ps2_data_i           (ps2k_data_i),
        .ps2_clk_drive_low_o  (ps2k_clk_drive_low_o),
        .ps2_data_drive_low_o (ps2k_data_drive_low_o),
        .code_o               (ps2k_code),
        .code_v_o             (ps2k_code_v),
        .cmd                  (cmd_if)
    );

    scan_fifo #(.DEPTH_LOG2(`SMC_FIFO_DEPTH_LOG2)) kbdfifo_i (
        .clk6x   (clk6x),
        .resetn  (resetn),
        .wdata_i (ps2k_code),
        .wenq_i  (fifo_enq),
        .rdata_o (fifo_rdata),
        .rdeq_i  (fifo_deq),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    smc_regs regs_i (
        .clk6x        (clk6x),
        .resetn       (resetn),
        .dev          (dev_if),
        .cmd          (cmd_if),
        .code_i       (ps2k_code),
        .code_v_i     (ps2k_code_v),
        .fifo_rdata_i (fifo_rdata),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .fifo_enq_o   (fifo_enq),
        .fifo_deq_o   (fifo_deq)
    );

endmodule

//--- smc_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register decoder
// maps i2c transfers onto the scan-code buffer, the command
// status and the ps2 command path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "smc_macros.svh"

module smc_regs (
    input  logic               clk6x,
    input  logic               resetn,
    i2c_dev_if.regs            dev,
    ps2_cmd_if.host            cmd,
    input  smc_pkg::smc_byte_t code_i,
    input  logic               code_v_i,
    input  smc_pkg::smc_byte_t fifo_rdata_i,
    input  logic               fifo_empty_i,
    input  logic               fifo_full_i,
    output logic               fifo_enq_o,
    output logic               fifo_deq_o
);
    import smc_pkg::*;

    smc_byte_t     regnum;          // set by first written byte
    ps2_cmd_stat_e stat;
    logic [1:0]    byteidx;         // 0 regnum, 1 data, 2 ignored

    // full buffer drops the code; 0x00 would read as empty
    assign fifo_enq_o = code_v_i & ~fifo_full_i & (code_i != 8'h00);

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            dev.txbyte <= 8'hFF;
            regnum <= 8'h00;
            stat <= IDLE;
            byteidx <= '0;
            cmd.cmd_v <= 1'b0;
            fifo_deq_o <= 1'b0;
        end
        else
        begin
            fifo_deq_o <= 1'b0;
            if (cmd.cmd_v && !cmd.busy)
                cmd.cmd_v <= 1'b0;          // port took it this cycle

            if (cmd.acked)
                stat <= ACK;
            else if (cmd.errd)
                stat <= ERR;

            if (!dev.devsel)
                byteidx <= '0;              // new transfer
            else if (dev.rxbyte_v)
            begin
                if (byteidx == 2'd0)
                    regnum <= dev.rxbyte;
                else if (byteidx == 2'd1 && regnum == `SMCREG_KBD_CMD)
                begin
                    cmd.cmd <= dev.rxbyte;
                    cmd.cmd_v <= 1'b1;
                    stat <= PENDING;
                end
                if (byteidx != 2'd2)
                    byteidx <= byteidx + 2'd1;
            end

            // keep txbyte current while the host reads
            if (dev.devsel && dev.rw_bit)
            begin
                case (regnum)
                    `SMCREG_KBD_BUF:  dev.txbyte <= fifo_empty_i ? 8'h00 : fifo_rdata_i;
                    `SMCREG_KBD_STAT: dev.txbyte <= stat;
                    default:          dev.txbyte <= 8'hFF;
                endcase
                // pop only a real code, never the empty marker
                if (dev.txbyte_deq && regnum == `SMCREG_KBD_BUF && dev.txbyte != 8'h00)
                    fifo_deq_o <= 1'b1;
            end
        end
    end

endmodule

//--- scan_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan-code buffer
// circular fifo, first word fall through, full and empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "smc_macros.svh"

module scan_fifo #(
    parameter int DEPTH_LOG2 = `SMC_FIFO_DEPTH_LOG2
) (
    input  logic               clk6x,
    input  logic               resetn,
    input  smc_pkg::smc_byte_t wdata_i,
    input  logic               wenq_i,
    output smc_pkg::smc_byte_t rdata_o,     // valid while empty_o low
    input  logic               rdeq_i,
    output logic               full_o,
    output logic               empty_o
);
    import smc_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    smc_byte_t mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wptr;
    logic [DEPTH_LOG2-1:0] rptr;
    logic [DEPTH_LOG2:0]   count;       // one extra bit for full

    assign rdata_o = mem[rptr];         // head, moves after a dequeue
    assign full_o  = (count == (DEPTH_LOG2 + 1)'(DEPTH));
    assign empty_o = (count == '0);

    always_ff @(posedge clk6x)
    begin
        if (wenq_i)
            mem[wptr] <= wdata_i;
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end
        else
        begin
            if (wenq_i)
                wptr <= wptr + 1'b1;    // wraps
            if (rdeq_i)
                rptr <= rptr + 1'b1;
            if (wenq_i && !rdeq_i)
                count <= count + 1'b1;
            else if (rdeq_i && !wenq_i)
                count <= count - 1'b1;
        end
    end

    a_no_ovf: assert property (@(posedge clk6x) disable iff (!resetn) full_o |-> !wenq_i);
    a_no_unf: assert property (@(posedge clk6x) disable iff (!resetn) empty_o |-> !rdeq_i);

endmodule

//--- ps2_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ps2 host port
// 1 us tick, frame receive with parity check, command
// transmit with inhibit, device ack sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "smc_macros.svh"

module ps2_port (
    input  logic               clk6x,
    input  logic               resetn,
    input  logic               ps2_clk_i,
    input  logic               ps2_data_i,
    output logic               ps2_clk_drive_low_o,
    output logic               ps2_data_drive_low_o,
    output smc_pkg::smc_byte_t code_o,
    output logic               code_v_o,
    ps2_cmd_if.port            cmd
);
    import smc_pkg::*;

    localparam int US_W = $clog2(`SMC_CLKS_PER_US);

    typedef enum logic [1:0] {P_IDLE, P_RX, P_INHIBIT, P_TX} ps2_state_e;

    ps2_state_e  state;
    logic [US_W-1:0] us_cnt;
    logic        us_tick;
    logic [6:0]  inh_cnt;       // 100 us clock inhibit
    logic [3:0]  bitcnt;
    logic [2:0]  clk_q;         // [1] synced, [2] previous
    logic [2:0]  data_q;
    smc_byte_t   rx_sh;
    logic        rx_par;
    logic        rx_stop;
    logic        rx_done;       // frame complete, checked next cycle
    logic [9:0]  tx_sh;         // stop, parity, data lsb first

    wire clk_fall = clk_q[2] & ~clk_q[1];
    wire data_s   = data_q[1];

    assign cmd.busy = (state != P_IDLE);

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            us_cnt <= '0;
            us_tick <= 1'b0;
        end
        else if (us_cnt == US_W'(`SMC_CLKS_PER_US - 1))
        begin
            us_cnt <= '0;
            us_tick <= 1'b1;
        end
        else
        begin
            us_cnt <= us_cnt + 1'b1;
            us_tick <= 1'b0;
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            clk_q <= '1;
            data_q <= '1;
            state <= P_IDLE;
            bitcnt <= '0;
            ps2_clk_drive_low_o <= 1'b0;
            ps2_data_drive_low_o <= 1'b0;
            rx_done <= 1'b0;
            code_v_o <= 1'b0;
            cmd.acked <= 1'b0;
            cmd.errd <= 1'b0;
        end
        else
        begin
            clk_q <= {clk_q[1:0], ps2_clk_i};
            data_q <= {data_q[1:0], ps2_data_i};
            rx_done <= 1'b0;
            cmd.acked <= 1'b0;
            cmd.errd <= 1'b0;
            // good frame: stop high, odd parity over data+parity
            code_v_o <= rx_done & rx_stop & (^{rx_sh, rx_par});
            code_o <= rx_sh;

            case (state)
                P_IDLE:
                    if (cmd.cmd_v)
                    begin
                        tx_sh <= {1'b1, ~^cmd.cmd, cmd.cmd};
                        inh_cnt <= '0;
                        ps2_clk_drive_low_o <= 1'b1;    // inhibit device
                        state <= P_INHIBIT;
                    end
                    else if (clk_fall && !data_s)
                    begin
                        bitcnt <= '0;                   // start bit seen
                        state <= P_RX;
                    end
                P_RX:
                    if (clk_fall)
                    begin
                        bitcnt <= bitcnt + 4'd1;
                        if (bitcnt < 4'd8)
                            rx_sh <= {data_s, rx_sh[7:1]};  // lsb first
                        else if (bitcnt == 4'd8)
                            rx_par <= data_s;
                        else
                        begin
                            rx_stop <= data_s;
                            rx_done <= 1'b1;
                            state <= P_IDLE;
                        end
                    end
                P_INHIBIT:
                    if (us_tick)
                    begin
                        inh_cnt <= inh_cnt + 7'd1;
                        if (inh_cnt == 7'd99)
                        begin
                            ps2_data_drive_low_o <= 1'b1;   // start bit
                            ps2_clk_drive_low_o <= 1'b0;    // device clocks now
                            bitcnt <= '0;
                            state <= P_TX;
                        end
                    end
                P_TX:
                    if (clk_fall)
                    begin
                        if (bitcnt != 4'd10)
                        begin
                            ps2_data_drive_low_o <= ~tx_sh[0];
                            tx_sh <= {1'b0, tx_sh[9:1]};
                            bitcnt <= bitcnt + 4'd1;
                        end
                        else
                        begin
                            // ack slot, device pulls data low
                            cmd.acked <= ~data_s;
                            cmd.errd <= data_s;
                            state <= P_IDLE;
                        end
                    end
                default: state <= P_IDLE;
            endcase
        end
    end

    // result pulses exclusive, both lines released once the stop bit went out
    a_ack_excl: assert property (@(posedge clk6x) disable iff (!resetn)
        (cmd.acked || cmd.errd) |->
            !(cmd.acked && cmd.errd) && !ps2_data_drive_low_o && !ps2_clk_drive_low_o);

endmodule

//--- i2c_target.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c target bit engine
// start/stop detect, address match, byte rx and tx with ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "smc_macros.svh"

module i2c_target (
    input  logic      clk6x,
    input  logic      resetn,
    input  logic      sda_i,
    input  logic      scl_i,
    output logic      sda_drive_low_o,      // 1 = pull sda low
    i2c_dev_if.target dev
);
    import smc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,         // not addressed, wait for start
        S_ADDR,         // shifting address byte
        S_AACK,         // address ack slot
        S_RX,           // host writes
        S_RACK,         // our ack after rx byte
        S_TX,           // host reads
        S_TACK,         // host ack slot
        S_TLOAD         // wait for fall, then next byte
    } i2c_state_e;

    i2c_state_e state;
    logic [2:0] scl_q;      // [1] synced, [2] previous
    logic [2:0] sda_q;
    logic [2:0] bitcnt;
    smc_byte_t  shreg;

    wire scl_s     = scl_q[1];
    wire sda_s     = sda_q[1];
    wire scl_rise  = scl_q[1] & ~scl_q[2];
    wire scl_fall  = ~scl_q[1] & scl_q[2];
    // sda moves while scl high
    wire start_det = scl_s & scl_q[2] & sda_q[2] & ~sda_q[1];
    wire stop_det  = scl_s & scl_q[2] & ~sda_q[2] & sda_q[1];

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            scl_q <= '1;                // bus idle high
            sda_q <= '1;
            state <= S_IDLE;
            bitcnt <= '0;
            sda_drive_low_o <= 1'b0;
            dev.devsel <= 1'b0;
            dev.rw_bit <= 1'b0;
            dev.rxbyte_v <= 1'b0;
            dev.txbyte_deq <= 1'b0;
        end
        else
        begin
            scl_q <= {scl_q[1:0], scl_i};
            sda_q <= {sda_q[1:0], sda_i};
            dev.rxbyte_v <= 1'b0;
            dev.txbyte_deq <= 1'b0;

            if (start_det)
            begin
                // also a repeated start
                state <= S_ADDR;
                bitcnt <= '0;
                sda_drive_low_o <= 1'b0;
                dev.devsel <= 1'b0;
            end
            else if (stop_det)
            begin
                state <= S_IDLE;
                sda_drive_low_o <= 1'b0;
                dev.devsel <= 1'b0;
            end
            else
            begin
                case (state)
                    S_ADDR:
                        if (scl_rise)
                        begin
                            shreg <= {shreg[6:0], sda_s};
                            bitcnt <= bitcnt + 3'd1;
                            if (bitcnt == 3'd7)
                            begin
                                // shreg[6:0] is the address, sda is r/w
                                if (shreg[6:0] == `SMC_I2C_ADDR)
                                begin
                                    dev.devsel <= 1'b1;
                                    dev.rw_bit <= sda_s;
                                    state <= S_AACK;
                                end
                                else
                                    state <= S_IDLE;    // not us
                            end
                        end
                    S_AACK, S_RACK:
                        if (scl_fall)
                        begin
                            if (!sda_drive_low_o)
                                sda_drive_low_o <= 1'b1;    // ack slot opens
                            else if (state == S_AACK && dev.rw_bit)
                            begin
                                shreg <= {dev.txbyte[6:0], 1'b0};
                                sda_drive_low_o <= ~dev.txbyte[7];  // msb out
                                bitcnt <= '0;
                                state <= S_TX;
                            end
                            else
                            begin
                                sda_drive_low_o <= 1'b0;
                                bitcnt <= '0;
                                state <= S_RX;
                            end
                        end
                    S_RX:
                        if (scl_rise)
                        begin
                            shreg <= {shreg[6:0], sda_s};
                            bitcnt <= bitcnt + 3'd1;
                            if (bitcnt == 3'd7)
                            begin
                                dev.rxbyte <= {shreg[6:0], sda_s};
                                dev.rxbyte_v <= 1'b1;
                                state <= S_RACK;
                            end
                        end
                    S_TX:
                        if (scl_fall)
                        begin
                            sda_drive_low_o <= ~shreg[7];
                            shreg <= {shreg[6:0], 1'b0};
                        end
                        else if (scl_rise)
                        begin
                            bitcnt <= bitcnt + 3'd1;
                            if (bitcnt == 3'd7)
                                state <= S_TACK;
                        end
                    S_TACK:
                        if (scl_fall)
                            sda_drive_low_o <= 1'b0;    // let host drive ack
                        else if (scl_rise)
                        begin
                            dev.txbyte_deq <= 1'b1;     // byte consumed, ack or nack
                            state <= sda_s ? S_IDLE : S_TLOAD;
                        end
                    S_TLOAD:
                        if (scl_fall)
                        begin
                            shreg <= {dev.txbyte[6:0], 1'b0};
                            sda_drive_low_o <= ~dev.txbyte[7];
                            bitcnt <= '0;
                            state <= S_TX;
                        end
                    default: ;
                endcase
            end
        end
    end

    // strobes only inside a selected transfer
    a_strobe_sel: assert property (@(posedge clk6x) disable iff (!resetn)
        (dev.rxbyte_v || dev.txbyte_deq) |-> dev.devsel);

endmodule

//--- smc_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// internal links of the controller
// i2c target to register decoder, decoder to ps2 port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface i2c_dev_if;
    import smc_pkg::*;

    logic      devsel;          // selected, address match to stop
    logic      rw_bit;          // 1 = host reads, valid with devsel
    smc_byte_t rxbyte;          // byte written by host
    logic      rxbyte_v;        // 1T strobe
    smc_byte_t txbyte;          // next byte for host, valid while reading
    logic      txbyte_deq;      // 1T, host has taken txbyte

    modport target (output devsel, rw_bit, rxbyte, rxbyte_v, txbyte_deq, input txbyte);
    modport regs   (input devsel, rw_bit, rxbyte, rxbyte_v, txbyte_deq, output txbyte);
endinterface

interface ps2_cmd_if;
    import smc_pkg::*;

    smc_byte_t cmd;             // command byte
    logic      cmd_v;           // held until taken
    logic      busy;            // port in rx or tx
    logic      acked;           // 1T, device acked
    logic      errd;            // 1T, device nacked

    modport host (output cmd, cmd_v, input busy, acked, errd);
    modport port (input cmd, cmd_v, output busy, acked, errd);
endinterface

//--- smc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system management controller types
// data byte and ps2 command status codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package smc_pkg;

    typedef logic [7:0] smc_byte_t;

    // values as returned through register 0x18
    typedef enum logic [7:0] {
        IDLE    = 8'h00,        // nothing sent yet
        PENDING = 8'h01,        // command in flight
        ACK     = 8'hFA,        // device took the command
        ERR     = 8'hFE         // device nacked
    } ps2_cmd_stat_e;

endpackage

//--- smc_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system management controller constants
// bus address, register map, buffer size, timing divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SMC_MACROS_SVH
`define SMC_MACROS_SVH

`define SMC_I2C_ADDR 7'h42          // 7-bit target address

// register numbers seen by the i2c host
`define SMCREG_KBD_BUF  8'h07       // pop keyboard scan code
`define SMCREG_KBD_STAT 8'h18       // ps2 command status
`define SMCREG_KBD_CMD  8'h19       // send ps2 command byte

`define SMC_FIFO_DEPTH_LOG2 3       // 8 entries
`define SMC_CLKS_PER_US 48          // clk6x at 48 MHz

`endif
